//--- all.f
source/bus_pkg.sv
source/master_port_if.sv
source/slave_port_if.sv
source/bus_arbiter.sv
source/address_decoder.sv
source/bus_switch.sv
source/bus_interconnect.sv
verif/bus_interconnect_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary -j 0 --top-module bus_interconnect_tb -f all.f

./obj_dir/Vbus_interconnect_tb | tee sim.log

if grep -qx "Simulation completed successfully" sim.log; then
	echo "run passed"
else
	echo "run did not pass, see sim.log"
	exit 1
fi

//--- verif/bus_interconnect_tb.sv
module bus_interconnect_tb;

	timeunit 1ns;
	timeprecision 10ps;

	import bus_pkg::*;

	localparam int ADDR_W     = DEFAULT_ADDR_W;
	localparam int DATA_W     = DEFAULT_DATA_W;
	localparam int N_XFER     = 200;
	// 400 transfers at up to 8 cycles each, plus margin
	localparam int MAX_CYCLES = 5000;

	logic sys_clk, reset;
	logic m1_valid, m1_write, m1_ready, m1_error, m1_grant;
	logic m2_valid, m2_write, m2_ready, m2_error, m2_grant;
	logic s1_valid, s1_write, s1_ready, s2_valid, s2_write, s2_ready;
	logic s3_valid, s3_write, s3_ready;
	logic [ADDR_W-1:0] m1_addr, m2_addr, s1_addr, s2_addr, s3_addr;
	logic [DATA_W-1:0] m1_wdata, m2_wdata, m1_rdata, m2_rdata;
	logic [DATA_W-1:0] s1_wdata, s2_wdata, s3_wdata, s1_rdata, s2_rdata, s3_rdata;

	// driven side, index 0 is m1 or s1
	logic [1:0]             m_valid;
	logic [1:0]             m_write;
	logic [1:0][ADDR_W-1:0] m_addr;
	logic [1:0][DATA_W-1:0] m_wdata;
	logic [2:0]             sl_ready;
	logic [2:0][DATA_W-1:0] sl_rdata;

	wire [1:0]             m_ready = {m2_ready, m1_ready};
	wire [1:0]             m_error = {m2_error, m1_error};
	wire [1:0]             m_grant = {m2_grant, m1_grant};
	wire [1:0][DATA_W-1:0] m_rdata = {m2_rdata, m1_rdata};
	wire [2:0]             s_valid = {s3_valid, s2_valid, s1_valid};
	wire [2:0]             s_write = {s3_write, s2_write, s1_write};
	wire [2:0][ADDR_W-1:0] s_addr  = {s3_addr, s2_addr, s1_addr};
	wire [2:0][DATA_W-1:0] s_wdata = {s3_wdata, s2_wdata, s1_wdata};

	integer            seed;
	int unsigned       cycle_count;
	int                issued [2];
	int                gap [2];
	logic [1:0]        done;
	logic [2:0]        pending;
	int                delay [3];
	logic [DATA_W-1:0] slave_mem [3][64];
	logic [DATA_W-1:0] ref_mem [3][64];
	// expected arbiter state, own is 1 for m2
	logic              owned;
	logic              own;
	logic              prefer_m2;
	int                n_write;
	int                n_read;
	int                n_refused;
	int                errors [6];
	string             test_name [6] = '{"reset", "write routing", "read return", "refusal",
		"arbitration", "back-pressure"};

	assign m1_valid = m_valid[0];
	assign m1_addr  = m_addr[0];
	assign m1_wdata = m_wdata[0];
	assign m1_write = m_write[0];
	assign m2_valid = m_valid[1];
	assign m2_addr  = m_addr[1];
	assign m2_wdata = m_wdata[1];
	assign m2_write = m_write[1];
	assign s1_ready = sl_ready[0];
	assign s1_rdata = sl_rdata[0];
	assign s2_ready = sl_ready[1];
	assign s2_rdata = sl_rdata[1];
	assign s3_ready = sl_ready[2];
	assign s3_rdata = sl_rdata[2];

	bus_interconnect #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_dut (.*);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge sys_clk);
			cycle_count++;
		end
		$display("timeout: traffic still running after %0d cycles", MAX_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	task automatic report_error(input logic [2:0] id, input string msg);
		errors[id]++;
		$display("** Error at %0t ns: %s: %s", $time, test_name[id], msg);
	endtask

	// unmapped top region, or a write to read-only slave 3
	function automatic logic is_refused(input logic [1:0] region, input logic write);
		return (region == 2'd3) || (write && region == 2'd2);
	endfunction

	task automatic sample_edge();
		logic       refused;
		logic [1:0] region;
		logic [1:0] exp_grant;
		logic [1:0] exp_ready;
		logic [2:0] exp_valid;
		refused   = 1'b0;
		region    = m_addr[own][ADDR_W-1 -: 2];
		exp_grant = '0;
		exp_ready = '0;
		exp_valid = '0;
		if (owned) begin
			refused        = is_refused(region, m_write[own]);
			exp_grant[own] = 1'b1;
			if (refused) begin
				exp_ready[own] = 1'b1;
			end else begin
				exp_valid[region] = 1'b1;
				exp_ready[own]    = sl_ready[region];
			end
		end
		if (m_grant != exp_grant) begin
			report_error(3'd4, $sformatf("grant %b, expected %b", m_grant, exp_grant));
		end
		if (s_valid != exp_valid) begin
			report_error(refused ? 3'd3 : 3'd1,
				$sformatf("slave valid %b, expected %b", s_valid, exp_valid));
		end
		if (exp_valid != '0 && (s_addr[region] != m_addr[own]
				|| s_wdata[region] != m_wdata[own] || s_write[region] != m_write[own])) begin
			report_error(3'd1, $sformatf("slave %0d request differs from owner", region + 1));
		end
		if (m_ready != exp_ready) begin
			report_error(3'd5, $sformatf("master ready %b, expected %b", m_ready, exp_ready));
		end
		if (owned && exp_ready[own]) begin
			if (m_error[own] != refused) begin
				report_error(refused ? 3'd3 : 3'd2,
					$sformatf("m%0d error %b, expected %b", own + 1, m_error[own], refused));
			end
			if (refused) begin
				n_refused++;
				if (m_rdata[own] != '0) begin
					report_error(3'd3, $sformatf("m%0d rdata %h on refusal", own + 1, m_rdata[own]));
				end
			end else if (m_write[own]) begin
				n_write++;
				ref_mem[region][m_addr[own][5:0]] = m_wdata[own];
			end else begin
				n_read++;
				if (m_rdata[own] != ref_mem[region][m_addr[own][5:0]]) begin
					report_error(3'd2, $sformatf("m%0d read %h, expected %h", own + 1,
						m_rdata[own], ref_mem[region][m_addr[own][5:0]]));
				end
			end
			done[own] = 1'b1;
		end
		for (logic [1:0] s = 2'd0; s < 2'd3; s++) begin
			if (s_valid[s] && sl_ready[s] && s_write[s]) begin
				slave_mem[s][s_addr[s][5:0]] = s_wdata[s];
			end
		end
		// idle bus grants on valid, a tie goes to the master that did not own last
		if (!owned && m_valid != 2'b00) begin
			owned     = 1'b1;
			own       = (m_valid == 2'b11) ? prefer_m2 : m_valid[1];
			prefer_m2 = !own;
		end else if (owned && exp_ready[own]) begin
			owned = 1'b0;
		end
	endtask

	task automatic drive_slave(input logic [1:0] s);
		if (!s_valid[s]) begin
			pending[s] = 1'b0;
		end else if (!pending[s]) begin
			// new request, pick its latency
			pending[s] = 1'b1;
			delay[s]   = $random(seed) & 3;
		end
		sl_ready[s] = pending[s] && delay[s] == 0;
		if (sl_ready[s]) begin
			sl_rdata[s] = slave_mem[s][s_addr[s][5:0]];
		end else begin
			sl_rdata[s] = DATA_W'($random(seed));
			if (pending[s]) begin
				delay[s]--;
			end
		end
	endtask

	task automatic drive_master(input logic m);
		if (done[m]) begin
			done[m]    = 1'b0;
			m_valid[m] = 1'b0;
			gap[m]     = $unsigned($random(seed)) % 3;
		end
		if (!m_valid[m] && issued[m] < N_XFER) begin
			if (gap[m] > 0) begin
				gap[m]--;
			end else begin
				// top two address bits pick the region at random
				m_valid[m] = 1'b1;
				m_addr[m]  = ADDR_W'($random(seed));
				m_wdata[m] = DATA_W'($random(seed));
				m_write[m] = 1'($random(seed));
				issued[m]++;
			end
		end
	endtask

	initial begin
		int total;
		total     = 0;
		seed      = 32'hb9e7e1b8;
		reset     = 1'b1;
		// both masters request while reset is held
		m_valid   = '1;
		m_write   = '0;
		m_addr    = '0;
		m_wdata   = '0;
		sl_ready  = '0;
		sl_rdata  = '0;
		done      = '0;
		pending   = '0;
		owned     = 1'b0;
		own       = 1'b0;
		prefer_m2 = 1'b0;
		for (logic [1:0] s = 2'd0; s < 2'd3; s++) begin
			for (int a = 0; a < 64; a++) begin
				slave_mem[s][a[5:0]] = DATA_W'(32'h5a000000 ^ (32'(s) << 20) ^ (a * 32'h00010203));
				ref_mem[s][a[5:0]]   = slave_mem[s][a[5:0]];
			end
		end
		for (int c = 0; c < 5; c++) begin
			@(negedge sys_clk);
			if (m_grant != '0 || s_valid != '0 || m_ready != '0) begin
				report_error(3'd0, $sformatf("grant %b, slave valid %b, ready %b",
					m_grant, s_valid, m_ready));
			end
			// four cycles in reset, then one idle cycle
			if (c == 3) begin
				reset   = 1'b0;
				m_valid = '0;
			end
		end
		$display("%s: %0d errors", test_name[0], errors[0]);
		while (issued[0] < N_XFER || issued[1] < N_XFER || m_valid != 2'b00 || owned) begin
			// mid low phase, the values the next rising edge will see
			#1;
			sample_edge();
			@(negedge sys_clk);
			drive_slave(2'd0);
			drive_slave(2'd1);
			drive_slave(2'd2);
			drive_master(1'b0);
			drive_master(1'b1);
		end
		for (logic [2:0] t = 3'd0; t < 3'd6; t++) begin
			total += errors[t];
			if (t != 3'd0) begin
				$display("%s: %0d errors", test_name[t], errors[t]);
			end
		end
		$display("%0d writes, %0d reads, %0d refused, %0d errors", n_write, n_read,
			n_refused, total);
		if (total == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- source/bus_interconnect.sv
module bus_interconnect #(
	parameter int ADDR_W = bus_pkg::DEFAULT_ADDR_W,
	parameter int DATA_W = bus_pkg::DEFAULT_DATA_W
) (
	input  logic              sys_clk,
	input  logic              reset,

	// master 1
	input  logic              m1_valid,
	input  logic [ADDR_W-1:0] m1_addr,
	input  logic [DATA_W-1:0] m1_wdata,
	input  logic              m1_write,
	output logic              m1_ready,
	output logic [DATA_W-1:0] m1_rdata,
	output logic              m1_error,
	output logic              m1_grant,

	// master 2
	input  logic              m2_valid,
	input  logic [ADDR_W-1:0] m2_addr,
	input  logic [DATA_W-1:0] m2_wdata,
	input  logic              m2_write,
	output logic              m2_ready,
	output logic [DATA_W-1:0] m2_rdata,
	output logic              m2_error,
	output logic              m2_grant,

	// slaves
	output logic              s1_valid,
	output logic [ADDR_W-1:0] s1_addr,
	output logic [DATA_W-1:0] s1_wdata,
	output logic              s1_write,
	input  logic              s1_ready,
	input  logic [DATA_W-1:0] s1_rdata,

	output logic              s2_valid,
	output logic [ADDR_W-1:0] s2_addr,
	output logic [DATA_W-1:0] s2_wdata,
	output logic              s2_write,
	input  logic              s2_ready,
	input  logic [DATA_W-1:0] s2_rdata,

	output logic              s3_valid,
	output logic [ADDR_W-1:0] s3_addr,
	output logic [DATA_W-1:0] s3_wdata,
	output logic              s3_write,
	input  logic              s3_ready,
	input  logic [DATA_W-1:0] s3_rdata
);

	import bus_pkg::*;

	owner_e     owner;
	slave_sel_e m1_sel;
	slave_sel_e m2_sel;
	logic       m1_fault;
	logic       m2_fault;

	master_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) m1_bus ();
	master_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) m2_bus ();
	slave_port_if  #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) s1_bus ();
	slave_port_if  #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) s2_bus ();
	slave_port_if  #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) s3_bus ();

	// master pins to the bundles
	assign m1_bus.valid = m1_valid;
	assign m1_bus.addr  = m1_addr;
	assign m1_bus.wdata = m1_wdata;
	assign m1_bus.write = m1_write;
	assign m1_ready     = m1_bus.ready;
	assign m1_rdata     = m1_bus.rdata;
	assign m1_error     = m1_bus.error;

	assign m2_bus.valid = m2_valid;
	assign m2_bus.addr  = m2_addr;
	assign m2_bus.wdata = m2_wdata;
	assign m2_bus.write = m2_write;
	assign m2_ready     = m2_bus.ready;
	assign m2_rdata     = m2_bus.rdata;
	assign m2_error     = m2_bus.error;

	// slave bundles to the pins
	assign s1_valid     = s1_bus.valid;
	assign s1_addr      = s1_bus.addr;
	assign s1_wdata     = s1_bus.wdata;
	assign s1_write     = s1_bus.write;
	assign s1_bus.ready = s1_ready;
	assign s1_bus.rdata = s1_rdata;

	assign s2_valid     = s2_bus.valid;
	assign s2_addr      = s2_bus.addr;
	assign s2_wdata     = s2_bus.wdata;
	assign s2_write     = s2_bus.write;
	assign s2_bus.ready = s2_ready;
	assign s2_bus.rdata = s2_rdata;

	assign s3_valid     = s3_bus.valid;
	assign s3_addr      = s3_bus.addr;
	assign s3_wdata     = s3_bus.wdata;
	assign s3_write     = s3_bus.write;
	assign s3_bus.ready = s3_ready;
	assign s3_bus.rdata = s3_rdata;

	bus_arbiter i_arbiter (
		.sys_clk  (sys_clk),
		.reset    (reset),
		.m1       (m1_bus.arb),
		.m2       (m2_bus.arb),
		.owner    (owner),
		.m1_grant (m1_grant),
		.m2_grant (m2_grant)
	);

	address_decoder #(.ADDR_W(ADDR_W)) i_decoder (
		.m1       (m1_bus.dec),
		.m2       (m2_bus.dec),
		.m1_sel   (m1_sel),
		.m2_sel   (m2_sel),
		.m1_fault (m1_fault),
		.m2_fault (m2_fault)
	);

	bus_switch #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_switch (
		.owner    (owner),
		.m1_sel   (m1_sel),
		.m2_sel   (m2_sel),
		.m1_fault (m1_fault),
		.m2_fault (m2_fault),
		.m1       (m1_bus.sw),
		.m2       (m2_bus.sw),
		.s1       (s1_bus.sw),
		.s2       (s2_bus.sw),
		.s3       (s3_bus.sw)
	);

endmodule

//--- source/bus_switch.sv
module bus_switch #(
	parameter int ADDR_W = bus_pkg::DEFAULT_ADDR_W,
	parameter int DATA_W = bus_pkg::DEFAULT_DATA_W
) (
	input  bus_pkg::owner_e     owner,
	input  bus_pkg::slave_sel_e m1_sel,
	input  bus_pkg::slave_sel_e m2_sel,
	input  logic                m1_fault,
	input  logic                m2_fault,
	master_port_if.sw           m1,
	master_port_if.sw           m2,
	slave_port_if.sw            s1,
	slave_port_if.sw            s2,
	slave_port_if.sw            s3
);

	import bus_pkg::*;

	// owner's request
	logic              active;
	slave_sel_e        cur_sel;
	logic              cur_fault;
	logic [ADDR_W-1:0] cur_addr;
	logic [DATA_W-1:0] cur_wdata;
	logic              cur_write;

	// answered here instead of by a slave
	logic              refused;

	logic              resp_ready;
	logic [DATA_W-1:0] resp_rdata;

	always_comb begin
		active    = 1'b0;
		cur_sel   = SEL_NONE;
		cur_fault = 1'b0;
		cur_addr  = '0;
		cur_wdata = '0;
		cur_write = 1'b0;
		case (owner)
			OWN_M1: begin
				active    = m1.valid;
				cur_sel   = m1_sel;
				cur_fault = m1_fault;
				cur_addr  = m1.addr;
				cur_wdata = m1.wdata;
				cur_write = m1.write;
			end
			OWN_M2: begin
				active    = m2.valid;
				cur_sel   = m2_sel;
				cur_fault = m2_fault;
				cur_addr  = m2.addr;
				cur_wdata = m2.wdata;
				cur_write = m2.write;
			end
			default: begin
				active = 1'b0;
			end
		endcase
	end

	assign refused = cur_fault || (cur_sel == SEL_NONE);

	// payload goes to every slave, valid to only one
	assign s1.valid = active && !refused && (cur_sel == SEL_S1);
	assign s1.addr  = cur_addr;
	assign s1.wdata = cur_wdata;
	assign s1.write = cur_write;

	assign s2.valid = active && !refused && (cur_sel == SEL_S2);
	assign s2.addr  = cur_addr;
	assign s2.wdata = cur_wdata;
	assign s2.write = cur_write;

	assign s3.valid = active && !refused && (cur_sel == SEL_S3);
	assign s3.addr  = cur_addr;
	assign s3.wdata = cur_wdata;
	assign s3.write = cur_write;

	// refused accesses finish at once with zero data
	always_comb begin
		resp_ready = 1'b0;
		resp_rdata = '0;
		if (refused) begin
			resp_ready = 1'b1;
		end else begin
			case (cur_sel)
				SEL_S1: begin
					resp_ready = s1.ready;
					resp_rdata = s1.rdata;
				end
				SEL_S2: begin
					resp_ready = s2.ready;
					resp_rdata = s2.rdata;
				end
				SEL_S3: begin
					resp_ready = s3.ready;
					resp_rdata = s3.rdata;
				end
				default: begin
					resp_ready = 1'b1;
				end
			endcase
		end
	end

	// response reaches the owner only
	assign m1.ready = active && (owner == OWN_M1) && resp_ready;
	assign m1.rdata = (owner == OWN_M1) ? resp_rdata : '0;
	assign m1.error = active && (owner == OWN_M1) && refused;

	assign m2.ready = active && (owner == OWN_M2) && resp_ready;
	assign m2.rdata = (owner == OWN_M2) ? resp_rdata : '0;
	assign m2.error = active && (owner == OWN_M2) && refused;

endmodule

//--- source/address_decoder.sv
module address_decoder #(
	parameter int ADDR_W = bus_pkg::DEFAULT_ADDR_W
) (
	master_port_if.dec          m1,
	master_port_if.dec          m2,
	output bus_pkg::slave_sel_e m1_sel,
	output bus_pkg::slave_sel_e m2_sel,
	output logic                m1_fault,
	output logic                m2_fault
);

	import bus_pkg::*;

	logic [REGION_W-1:0] m1_region;
	logic [REGION_W-1:0] m2_region;

	function automatic slave_sel_e region_sel(input logic [REGION_W-1:0] region);
		case (region)
			REGION_S1: region_sel = SEL_S1;
			REGION_S2: region_sel = SEL_S2;
			REGION_S3: region_sel = SEL_S3;
			default:   region_sel = SEL_NONE;
		endcase
	endfunction

	// unmapped region, or a write to the read-only slave
	function automatic logic access_fault(
		input logic [REGION_W-1:0] region,
		input logic                write
	);
		access_fault = (region == REGION_NONE) || (write && (region == REGION_S3));
	endfunction

	assign m1_region = m1.addr[ADDR_W-1 -: REGION_W];
	assign m2_region = m2.addr[ADDR_W-1 -: REGION_W];

	// both masters decoded side by side
	assign m1_sel   = region_sel(m1_region);
	assign m2_sel   = region_sel(m2_region);

	assign m1_fault = access_fault(m1_region, m1.write);
	assign m2_fault = access_fault(m2_region, m2.write);

endmodule

//--- source/bus_arbiter.sv
module bus_arbiter (
	input  logic             sys_clk,
	input  logic             reset,
	master_port_if.arb       m1,
	master_port_if.arb       m2,
	output bus_pkg::owner_e  owner,
	output logic             m1_grant,
	output logic             m2_grant
);

	import bus_pkg::*;

	// round-robin pointer, set when m1 owned last
	logic   prefer_m2;
	logic   prefer_next;
	owner_e owner_next;

	always_comb begin
		owner_next  = owner;
		prefer_next = prefer_m2;
		case (owner)
			OWN_NONE: begin
				if (m1.valid && m2.valid) begin
					if (prefer_m2) begin
						owner_next = OWN_M2;
					end else begin
						owner_next = OWN_M1;
					end
				end else if (m1.valid) begin
					owner_next = OWN_M1;
				end else if (m2.valid) begin
					owner_next = OWN_M2;
				end
				// the winner goes to the back of the line
				if (owner_next == OWN_M1) begin
					prefer_next = 1'b1;
				end else if (owner_next == OWN_M2) begin
					prefer_next = 1'b0;
				end
			end
			OWN_M1: begin
				// release on the completed handshake
				if (m1.ready) begin
					owner_next = OWN_NONE;
				end
			end
			OWN_M2: begin
				if (m2.ready) begin
					owner_next = OWN_NONE;
				end
			end
			default: begin
				owner_next = OWN_NONE;
			end
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			owner     <= OWN_NONE;
			prefer_m2 <= 1'b0;
		end else begin
			owner     <= owner_next;
			prefer_m2 <= prefer_next;
		end
	end

	assign m1_grant = (owner == OWN_M1);
	assign m2_grant = (owner == OWN_M2);

endmodule

//--- source/slave_port_if.sv
interface slave_port_if #(
	parameter int ADDR_W = bus_pkg::DEFAULT_ADDR_W,
	parameter int DATA_W = bus_pkg::DEFAULT_DATA_W
) ();

	// request, held until the slave's ready
	logic              valid;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              write;

	// response
	logic              ready;
	logic [DATA_W-1:0] rdata;

	modport sw (
		output valid, addr, wdata, write,
		input  ready, rdata
	);

endinterface

//--- source/master_port_if.sv
interface master_port_if #(
	parameter int ADDR_W = bus_pkg::DEFAULT_ADDR_W,
	parameter int DATA_W = bus_pkg::DEFAULT_DATA_W
) ();

	// request, held by the master until ready
	logic              valid;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              write;

	// response, valid in the ready cycle
	logic              ready;
	logic [DATA_W-1:0] rdata;
	logic              error;

	modport arb (
		input valid,
		input ready
	);

	modport dec (
		input addr,
		input write
	);

	modport sw (
		input  valid, addr, wdata, write,
		output ready, rdata, error
	);

endinterface

//--- source/bus_pkg.sv
package bus_pkg;

	// default widths, the top level overrides them
	localparam int DEFAULT_ADDR_W = 16;
	localparam int DEFAULT_DATA_W = 32;

	// top address bits pick the region
	localparam int REGION_W = 2;

	localparam logic [REGION_W-1:0] REGION_S1   = 2'd0;
	localparam logic [REGION_W-1:0] REGION_S2   = 2'd1;
	// slave 3 is read-only
	localparam logic [REGION_W-1:0] REGION_S3   = 2'd2;
	localparam logic [REGION_W-1:0] REGION_NONE = 2'd3;

	// decoder result per master
	typedef enum logic [1:0] {
		SEL_S1   = 2'd0,
		SEL_S2   = 2'd1,
		SEL_S3   = 2'd2,
		SEL_NONE = 2'd3
	} slave_sel_e;

	// bus ownership, also the arbiter state
	typedef enum logic [1:0] {
		OWN_NONE = 2'd0,
		OWN_M1   = 2'd1,
		OWN_M2   = 2'd2
	} owner_e;

endpackage
